/* exu_pkg.sv */
package exu_pkg;

    localparam int op_w = 5;

    // single-cycle opcodes
    localparam logic [op_w-1:0] op_add    = 5'd0;
    localparam logic [op_w-1:0] op_sub    = 5'd1;
    localparam logic [op_w-1:0] op_pass_a = 5'd2;
    localparam logic [op_w-1:0] op_pass_b = 5'd3;
    localparam logic [op_w-1:0] op_xor    = 5'd4;
    localparam logic [op_w-1:0] op_or     = 5'd5;
    localparam logic [op_w-1:0] op_and    = 5'd6;
    localparam logic [op_w-1:0] op_sll    = 5'd7;
    localparam logic [op_w-1:0] op_srl    = 5'd8;
    localparam logic [op_w-1:0] op_sra    = 5'd9;
    localparam logic [op_w-1:0] op_slt    = 5'd10;
    localparam logic [op_w-1:0] op_sltu   = 5'd11;
    localparam logic [op_w-1:0] op_eq     = 5'd12;
    localparam logic [op_w-1:0] op_ge     = 5'd13;  // signed a >= b
    localparam logic [op_w-1:0] op_geu    = 5'd14;

    // multi-cycle opcodes, handled by the iterative units
    localparam logic [op_w-1:0] op_mul    = 5'd15;
    localparam logic [op_w-1:0] op_div    = 5'd16;
    localparam logic [op_w-1:0] op_divu   = 5'd17;
    localparam logic [op_w-1:0] op_rem    = 5'd18;
    localparam logic [op_w-1:0] op_remu   = 5'd19;

    // operand a source
    localparam logic [1:0] sel_a_pc  = 2'd0;
    localparam logic [1:0] sel_a_rs1 = 2'd1;

    // operand b source
    localparam logic [1:0] sel_b_imm = 2'd0;
    localparam logic [1:0] sel_b_rs2 = 2'd1;
    localparam logic [1:0] sel_b_csr = 2'd2;  // 2'd3 falls back to imm

endpackage

/* exu_operand_mux.sv */
`timescale 1ns/100ps

module exu_operand_mux import exu_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic [1:0]      sel_a,
    input  logic [1:0]      sel_b,
    input  logic            word32,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] csr,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] op_a,
    output logic [XLEN-1:0] op_b
);

    logic [XLEN-1:0] rs1_ext;

    // word ops see only the low half of rs1
    assign rs1_ext = word32 ? XLEN'(rs1[31:0]) : rs1;

    assign op_a = (sel_a == sel_a_rs1) ? rs1_ext : pc;

    always_comb begin
        case (sel_b)
            sel_b_rs2: op_b = rs2;
            sel_b_csr: op_b = csr;
            default:   op_b = imm;  // sel_b_imm and unused code
        endcase
    end

endmodule

/* exu_int_alu.sv */
`timescale 1ns/100ps

module exu_int_alu import exu_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic [op_w-1:0] op,
    input  logic            word32,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic [XLEN-1:0] alu_res
);

    localparam int SH_W = $clog2(XLEN);

    logic [SH_W-1:0] shamt;
    logic [31:0]     sra_word;
    logic            lt_s;
    logic            lt_u;

    assign shamt = op_b[SH_W-1:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    // 32-bit arithmetic shift for word mode, zero-filled above
    assign sra_word = $signed(op_a[31:0]) >>> shamt;

    always_comb begin
        case (op)
            op_add:    alu_res = op_a + op_b;
            op_sub:    alu_res = op_a - op_b;
            op_pass_a: alu_res = op_a;
            op_pass_b: alu_res = op_b;
            op_xor:    alu_res = op_a ^ op_b;
            op_or:     alu_res = op_a | op_b;
            op_and:    alu_res = op_a & op_b;
            op_sll:    alu_res = op_a << shamt;
            op_srl:    alu_res = op_a >> shamt;
            op_sra: begin
                if (word32) begin
                    alu_res = XLEN'(sra_word);
                end else begin
                    alu_res = $signed(op_a) >>> shamt;
                end
            end
            op_slt:    alu_res = XLEN'(lt_s);
            op_sltu:   alu_res = XLEN'(lt_u);
            op_eq:     alu_res = XLEN'(op_a == op_b);
            op_ge:     alu_res = XLEN'(!lt_s);
            op_geu:    alu_res = XLEN'(!lt_u);
            default:   alu_res = '0;  // mul/div go to the iterative units
        endcase
    end

endmodule

/* exu_multiplier.sv */
`timescale 1ns/100ps

module exu_multiplier #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mul_start,
    input  logic            flush,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic            mul_done,
    output logic [XLEN-1:0] mul_res
);

    localparam int CNT_W = $clog2(XLEN);

    logic             running;
    logic [CNT_W-1:0] cnt;      // bits consumed so far
    logic [XLEN-1:0]  mcand;    // shifts left each step
    logic [XLEN-1:0]  mplier;   // shifts right each step
    logic [XLEN-1:0]  acc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (flush) begin
                running <= 1'b0;
            end else if (mul_start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(XLEN - 1)) begin  // last bit this edge
                    running  <= 1'b0;
                    mul_done <= 1'b1;
                end
            end
        end
    end

    // shift-add datapath, only the low XLEN bits are kept
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= op_a;
            mplier <= op_b;
            acc    <= '0;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign mul_res = acc;

endmodule

/* exu_divider.sv */
`timescale 1ns/100ps

module exu_divider #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            div_start,
    input  logic            flush,
    input  logic            div_signed,
    input  logic [XLEN-1:0] op_a,
    input  logic [XLEN-1:0] op_b,
    output logic            div_done,
    output logic [XLEN-1:0] quot,
    output logic [XLEN-1:0] rem
);

    localparam int CNT_W = $clog2(XLEN);

    logic             running;
    logic             fixing;   // sign fix cycle after the loop
    logic [CNT_W-1:0] cnt;
    logic [XLEN-1:0]  divisor;
    logic [XLEN-1:0]  q_r;      // dividend shifts out, quotient shifts in
    logic [XLEN-1:0]  r_r;      // partial remainder
    logic             neg_q;
    logic             neg_r;
    logic [XLEN-1:0]  a_mag;
    logic [XLEN-1:0]  b_mag;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;

    assign a_mag = (div_signed && op_a[XLEN-1]) ? -op_a : op_a;
    assign b_mag = (div_signed && op_b[XLEN-1]) ? -op_b : op_b;

    assign shifted = {r_r, q_r[XLEN-1]};
    assign diff    = shifted - {1'b0, divisor};  // msb set means no subtract

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running  <= 1'b0;
            fixing   <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (flush) begin
                running <= 1'b0;
                fixing  <= 1'b0;
            end else if (div_start) begin
                running <= 1'b1;
                cnt     <= '0;
            end else if (running) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(XLEN - 1)) begin
                    running <= 1'b0;
                    fixing  <= 1'b1;
                end
            end else if (fixing) begin
                fixing   <= 1'b0;
                div_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor <= b_mag;
            q_r     <= a_mag;
            r_r     <= '0;
            // divide by zero keeps the all-ones quotient unsigned
            neg_q   <= div_signed && (op_a[XLEN-1] ^ op_b[XLEN-1]) && (|op_b);
            neg_r   <= div_signed && op_a[XLEN-1];
        end else if (running) begin
            if (!diff[XLEN]) begin
                r_r <= diff[XLEN-1:0];
                q_r <= {q_r[XLEN-2:0], 1'b1};
            end else begin
                r_r <= shifted[XLEN-1:0];
                q_r <= {q_r[XLEN-2:0], 1'b0};
            end
        end else if (fixing) begin
            if (neg_q) q_r <= -q_r;
            if (neg_r) r_r <= -r_r;  // remainder takes the dividend sign
        end
    end

    assign quot = q_r;
    assign rem  = r_r;

endmodule

/* exu_ctrl.sv */
`timescale 1ns/100ps

module exu_ctrl import exu_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  logic            flush,
    input  logic [op_w-1:0] op,
    input  logic [XLEN-1:0] alu_res,
    input  logic            mul_done,
    input  logic [XLEN-1:0] mul_res,
    input  logic            div_done,
    input  logic [XLEN-1:0] quot,
    input  logic [XLEN-1:0] rem,
    output logic            mul_start,
    output logic            div_start,
    output logic            div_signed,
    output logic [XLEN-1:0] res,
    output logic            busy
);

    logic is_mul;
    logic is_div;
    logic accept;
    logic div_rem_sel;  // 1 returns the remainder
    logic unit_done;

    assign is_mul = (op == op_mul);
    assign is_div = (op == op_div) || (op == op_divu) ||
                    (op == op_rem) || (op == op_remu);

    // issue while busy is dropped, flush wins over issue
    assign accept    = issue && !busy && !flush;
    assign unit_done = busy && (mul_done || div_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            mul_start   <= 1'b0;
            div_start   <= 1'b0;
            div_signed  <= 1'b0;
            div_rem_sel <= 1'b0;
            res         <= '0;
        end else begin
            mul_start <= 1'b0;  // strobes last one cycle
            div_start <= 1'b0;
            if (flush) begin
                busy <= 1'b0;   // res keeps its old value
            end else if (accept) begin
                if (is_mul) begin
                    busy      <= 1'b1;
                    mul_start <= 1'b1;
                end else if (is_div) begin
                    busy        <= 1'b1;
                    div_start   <= 1'b1;
                    div_signed  <= (op == op_div) || (op == op_rem);
                    div_rem_sel <= (op == op_rem) || (op == op_remu);
                end else begin
                    res <= alu_res;  // single-cycle result
                end
            end else if (unit_done) begin
                busy <= 1'b0;
                if (mul_done) begin
                    res <= mul_res;
                end else begin
                    res <= div_rem_sel ? rem : quot;
                end
            end
        end
    end

endmodule

/* exu_top.sv */
`timescale 1ns/100ps

module exu_top import exu_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            issue,
    input  logic            flush,
    input  logic [op_w-1:0] op,
    input  logic [1:0]      sel_a,
    input  logic [1:0]      sel_b,
    input  logic            word32,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic [XLEN-1:0] csr,
    input  logic [XLEN-1:0] imm,
    output logic [XLEN-1:0] res,
    output logic            busy
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            mul_start;
    logic            mul_done;
    logic [XLEN-1:0] mul_res;
    logic            div_start;
    logic            div_signed;
    logic            div_done;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;

    exu_operand_mux #(.XLEN(XLEN)) u_operand_mux (
        .sel_a  (sel_a),
        .sel_b  (sel_b),
        .word32 (word32),
        .pc     (pc),
        .rs1    (rs1),
        .rs2    (rs2),
        .csr    (csr),
        .imm    (imm),
        .op_a   (op_a),
        .op_b   (op_b)
    );

    exu_int_alu #(.XLEN(XLEN)) u_int_alu (
        .op      (op),
        .word32  (word32),
        .op_a    (op_a),
        .op_b    (op_b),
        .alu_res (alu_res)
    );

    exu_multiplier #(.XLEN(XLEN)) u_multiplier (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .flush     (flush),
        .op_a      (op_a),
        .op_b      (op_b),
        .mul_done  (mul_done),
        .mul_res   (mul_res)
    );

    exu_divider #(.XLEN(XLEN)) u_divider (
        .clk        (clk),
        .rst_n      (rst_n),
        .div_start  (div_start),
        .flush      (flush),
        .div_signed (div_signed),
        .op_a       (op_a),
        .op_b       (op_b),
        .div_done   (div_done),
        .quot       (quot),
        .rem        (rem)
    );

    exu_ctrl #(.XLEN(XLEN)) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .flush      (flush),
        .op         (op),
        .alu_res    (alu_res),
        .mul_done   (mul_done),
        .mul_res    (mul_res),
        .div_done   (div_done),
        .quot       (quot),
        .rem        (rem),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .div_signed (div_signed),
        .res        (res),
        .busy       (busy)
    );

endmodule

/* exu_top_sva.sv */
`timescale 1ns/100ps

module exu_top_sva #(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            rst_n,
    input logic            issue,
    input logic            flush,
    input logic            busy,
    input logic [XLEN-1:0] res
);

    // reset leaves the stage idle
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> !busy)
        else $error("busy high after reset");

    a_flush_clears: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !busy)
        else $error("busy still high after flush");

    a_busy_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
        !busy && !issue |=> !busy)
        else $error("busy rose without issue");

    // res may change only on the edge where busy falls
    a_res_stable: assert property (@(posedge clk) disable iff (!rst_n)
        busy |=> !busy || $stable(res))
        else $error("res changed while busy");

endmodule

bind exu_top exu_top_sva #(.XLEN(XLEN)) u_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue),
    .flush (flush),
    .busy  (busy),
    .res   (res)
);

/* tb_exu_top.sv */
`timescale 1ns/100ps

module tb_exu_top import exu_pkg::*; ();

    localparam int XLEN     = 64;
    localparam int MAX_ROWS = 40;

    logic            clk;
    logic            rst_n;
    logic            issue;
    logic            flush;
    logic [op_w-1:0] op;
    logic [1:0]      sel_a;
    logic [1:0]      sel_b;
    logic            word32;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic            busy;

    // stimulus table with one entry per operation
    logic [op_w-1:0] t_op [MAX_ROWS];
    logic [1:0]      t_sel_a [MAX_ROWS];
    logic [1:0]      t_sel_b [MAX_ROWS];
    logic            t_w32 [MAX_ROWS];
    logic [XLEN-1:0] t_pc [MAX_ROWS];
    logic [XLEN-1:0] t_rs1 [MAX_ROWS];
    logic [XLEN-1:0] t_rs2 [MAX_ROWS];
    logic [XLEN-1:0] t_csr [MAX_ROWS];
    logic [XLEN-1:0] t_imm [MAX_ROWS];
    int              t_flush_at [MAX_ROWS];    // cycles after issue or 0 for none
    int              t_reissue_at [MAX_ROWS];  // second issue while busy or 0 for none
    logic [XLEN-1:0] t_exp [MAX_ROWS];

    int num_rows    = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    int err_cnt     = 0;

    exu_top #(.XLEN(XLEN)) u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue),
        .flush  (flush),
        .op     (op),
        .sel_a  (sel_a),
        .sel_b  (sel_b),
        .word32 (word32),
        .pc     (pc),
        .rs1    (rs1),
        .rs2    (rs2),
        .csr    (csr),
        .imm    (imm),
        .res    (res),
        .busy   (busy)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation aborted on timeout");
        end
    end

    task automatic compare_value(input string what, input logic [XLEN-1:0] got,
                                 input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_row(input logic [op_w-1:0] o, input logic [1:0] sa,
                           input logic [1:0] sb, input logic w,
                           input logic [XLEN-1:0] p, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b, input logic [XLEN-1:0] c,
                           input logic [XLEN-1:0] i, input int fl, input int ri,
                           input logic [XLEN-1:0] e);
        t_op[num_rows]         = o;
        t_sel_a[num_rows]      = sa;
        t_sel_b[num_rows]      = sb;
        t_w32[num_rows]        = w;
        t_pc[num_rows]         = p;
        t_rs1[num_rows]        = a;
        t_rs2[num_rows]        = b;
        t_csr[num_rows]        = c;
        t_imm[num_rows]        = i;
        t_flush_at[num_rows]   = fl;
        t_reissue_at[num_rows] = ri;
        t_exp[num_rows]        = e;
        num_rows++;
    endtask

    task automatic run_row(input int n);
        logic [XLEN-1:0] exp_busy;
        logic [XLEN-1:0] held_res;
        exp_busy = XLEN'(t_op[n] >= op_mul);  // mul and div stall the stage
        held_res = (n > 0) ? t_exp[n-1] : '0;  // res left by the row before
        @(negedge clk);
        op     = t_op[n];
        sel_a  = t_sel_a[n];
        sel_b  = t_sel_b[n];
        word32 = t_w32[n];
        pc     = t_pc[n];
        rs1    = t_rs1[n];
        rs2    = t_rs2[n];
        csr    = t_csr[n];
        imm    = t_imm[n];
        issue  = 1'b1;
        @(negedge clk);
        issue = 1'b0;
        compare_value($sformatf("row %0d busy after issue", n), XLEN'(busy), exp_busy);
        if (t_reissue_at[n] > 0) begin
            repeat (t_reissue_at[n] - 1) @(negedge clk);
            op    = op_add;  // would overwrite res if accepted
            issue = 1'b1;
            @(negedge clk);
            issue = 1'b0;
            op    = t_op[n];
            compare_value($sformatf("row %0d busy after second issue", n), XLEN'(busy),
                          exp_busy);
            compare_value($sformatf("row %0d res after second issue", n), res, held_res);
        end
        if (t_flush_at[n] > 0) begin
            repeat (t_flush_at[n] - 1) @(negedge clk);
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            compare_value($sformatf("row %0d busy after flush", n), XLEN'(busy), '0);
        end
        while (busy) @(negedge clk);
        compare_value($sformatf("row %0d res", n), res, t_exp[n]);
    endtask

    initial begin
        rst_n  = 1'b0;
        issue  = 1'b0;
        flush  = 1'b0;
        op     = op_add;
        sel_a  = sel_a_rs1;
        sel_b  = sel_b_rs2;
        word32 = 1'b0;
        pc     = '0;
        rs1    = '0;
        rs2    = '0;
        csr    = '0;
        imm    = '0;

        // single-cycle ops and operand selects
        add_row(op_add, sel_a_rs1, sel_b_rs2, 0, 0, 64'd5, 64'd7, 0, 0, 0, 0, 64'd12);
        add_row(op_sub, sel_a_rs1, sel_b_rs2, 0, 0, 64'd5, 64'd7, 0, 0, 0, 0,
                64'hFFFF_FFFF_FFFF_FFFE);
        add_row(op_pass_a, sel_a_pc, sel_b_rs2, 0, 64'h1000, 64'd9, 0, 0, 0, 0, 0,
                64'h1000);
        add_row(op_pass_b, sel_a_rs1, sel_b_csr, 0, 0, 0, 64'd3, 64'hABCD, 0, 0, 0,
                64'hABCD);
        add_row(op_add, sel_a_pc, sel_b_imm, 0, 64'h1000, 64'd9, 64'd3, 0, 64'h24, 0, 0,
                64'h1024);
        add_row(op_xor, sel_a_rs1, sel_b_rs2, 0, 0, 64'hF0F0, 64'hFF00, 0, 0, 0, 0,
                64'h0FF0);
        add_row(op_or, sel_a_rs1, sel_b_rs2, 0, 0, 64'hF0F0, 64'h0F00, 0, 0, 0, 0,
                64'hFFF0);
        add_row(op_and, sel_a_rs1, sel_b_rs2, 0, 0, 64'hF0F0, 64'hFF00, 0, 0, 0, 0,
                64'hF000);
        add_row(op_sll, sel_a_rs1, sel_b_imm, 0, 0, 64'd1, 0, 0, 64'd63, 0, 0,
                64'h8000_0000_0000_0000);
        add_row(op_sll, sel_a_rs1, sel_b_imm, 0, 0, 64'd1, 0, 0, 64'h41, 0, 0, 64'd2);
        add_row(op_srl, sel_a_rs1, sel_b_imm, 0, 0, 64'h8000_0000_0000_0000, 0, 0,
                64'd4, 0, 0, 64'h0800_0000_0000_0000);
        add_row(op_sra, sel_a_rs1, sel_b_imm, 0, 0, 64'h8000_0000_0000_0000, 0, 0,
                64'd4, 0, 0, 64'hF800_0000_0000_0000);
        add_row(op_sra, sel_a_rs1, sel_b_imm, 1, 0, 64'hFFFF_FFFF_8000_0000, 0, 0,
                64'd4, 0, 0, 64'h0000_0000_F800_0000);
        add_row(op_add, sel_a_rs1, sel_b_rs2, 1, 0, 64'hFFFF_FFFF_0000_0001, 64'd1, 0,
                0, 0, 0, 64'd2);
        add_row(op_slt, sel_a_rs1, sel_b_rs2, 0, 0, '1, 64'd1, 0, 0, 0, 0, 64'd1);
        add_row(op_sltu, sel_a_rs1, sel_b_rs2, 0, 0, '1, 64'd1, 0, 0, 0, 0, 64'd0);
        add_row(op_eq, sel_a_rs1, sel_b_rs2, 0, 0, 64'h55, 64'h55, 0, 0, 0, 0, 64'd1);
        add_row(op_ge, sel_a_rs1, sel_b_rs2, 0, 0, '1, 64'd1, 0, 0, 0, 0, 64'd0);
        add_row(op_geu, sel_a_rs1, sel_b_rs2, 0, 0, '1, 64'd1, 0, 0, 0, 0, 64'd1);

        // multiply returns the low half of the product
        add_row(op_mul, sel_a_rs1, sel_b_rs2, 0, 0, 64'h1_0000_0001, 64'h1_0000_0003, 0,
                0, 0, 0, 64'h0000_0004_0000_0003);
        add_row(op_mul, sel_a_rs1, sel_b_rs2, 0, 0, 64'hFFFF_FFFF_FFFF_FFFD, 64'd7, 0,
                0, 0, 0, 64'hFFFF_FFFF_FFFF_FFEB);

        // division truncates toward zero
        add_row(op_div, sel_a_rs1, sel_b_rs2, 0, 0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd3, 0,
                0, 0, 0, 64'hFFFF_FFFF_FFFF_FFFA);
        add_row(op_rem, sel_a_rs1, sel_b_rs2, 0, 0, 64'hFFFF_FFFF_FFFF_FFEC, 64'd3, 0,
                0, 0, 0, 64'hFFFF_FFFF_FFFF_FFFE);
        add_row(op_div, sel_a_rs1, sel_b_rs2, 0, 0, 64'd20, 64'hFFFF_FFFF_FFFF_FFFD, 0,
                0, 0, 0, 64'hFFFF_FFFF_FFFF_FFFA);
        add_row(op_rem, sel_a_rs1, sel_b_rs2, 0, 0, 64'd20, 64'hFFFF_FFFF_FFFF_FFFD, 0,
                0, 0, 0, 64'd2);
        add_row(op_remu, sel_a_rs1, sel_b_rs2, 0, 0, 64'd100, 64'd7, 0, 0, 0, 0, 64'd2);
        add_row(op_divu, sel_a_rs1, sel_b_rs2, 0, 0, 64'd100, 64'd7, 0, 0, 0, 0, 64'd14);
        // flushed divide leaves the previous result and a plain add follows
        add_row(op_div, sel_a_rs1, sel_b_rs2, 0, 0, 64'd1000, 64'd7, 0, 0, 10, 0, 64'd14);
        add_row(op_add, sel_a_rs1, sel_b_rs2, 0, 0, 64'd3, 64'd4, 0, 0, 0, 0, 64'd7);
        // divide by zero
        add_row(op_div, sel_a_rs1, sel_b_rs2, 0, 0, 64'd5, 0, 0, 0, 0, 0, '1);
        add_row(op_rem, sel_a_rs1, sel_b_rs2, 0, 0, 64'hFFFF_FFFF_FFFF_FFFB, 0, 0, 0,
                0, 0, 64'hFFFF_FFFF_FFFF_FFFB);
        add_row(op_divu, sel_a_rs1, sel_b_rs2, 0, 0, 64'd9, 0, 0, 0, 0, 0, '1);
        add_row(op_remu, sel_a_rs1, sel_b_rs2, 0, 0, 64'd9, 0, 0, 0, 0, 0, 64'd9);
        // signed overflow
        add_row(op_div, sel_a_rs1, sel_b_rs2, 0, 0, 64'h8000_0000_0000_0000, '1, 0, 0,
                0, 0, 64'h8000_0000_0000_0000);
        add_row(op_rem, sel_a_rs1, sel_b_rs2, 0, 0, 64'h8000_0000_0000_0000, '1, 0, 0,
                0, 0, 64'd0);
        // second issue while the multiplier runs is dropped
        add_row(op_mul, sel_a_rs1, sel_b_rs2, 0, 0, 64'd6, 64'd7, 0, 0, 0, 5, 64'd42);

        cycle_limit = num_rows * (XLEN + 8) + 100;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        for (int n = 0; n < num_rows; n++) begin
            run_row(n);
        end

        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

/* exu_top.f */
exu_pkg.sv
exu_operand_mux.sv
exu_int_alu.sv
exu_multiplier.sv
exu_divider.sv
exu_ctrl.sv
exu_top.sv
exu_top_sva.sv
tb_exu_top.sv
